// ==== design/pf_consts.svh ====
`ifndef PF_CONSTS_SVH
`define PF_CONSTS_SVH

// Fetch address width
`define PF_ADDR_W 32
// Instruction word width
`define PF_DATA_W 32
// Default instruction queue depth
`define PF_FIFO_DEPTH 4
// Byte distance between consecutive words
`define PF_ADDR_STEP 4

`endif

// ==== design/pf_pkg.sv ====
`default_nettype none

`include "pf_consts.svh"

package pf_pkg;

  // IDLE has no stale cycle pending
  // BRANCH_WAIT drops the response of a cycle opened before the branch
  typedef enum logic {
    IDLE        = 1'b0,
    BRANCH_WAIT = 1'b1
  } prefetch_state_e;

  // Request from controller to bus master
  typedef struct packed {
    logic [`PF_ADDR_W-1:0] addr;
  } trans_req_t;

  // Fetched word tagged with its own address
  typedef struct packed {
    logic [`PF_ADDR_W-1:0] addr;
    logic [`PF_DATA_W-1:0] instr;
  } instr_resp_t;

  // Wishbone classic master outputs, read only
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic [`PF_ADDR_W-1:0] adr;
  } wb_m2s_t;

endpackage

`default_nettype wire

// ==== design/prefetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pf_consts.svh"

module prefetch_ctrl (
  input  logic                                clk,
  input  logic                                rst_n,
  // Redirect from the core
  input  logic                                branch_i,
  input  logic [`PF_ADDR_W-1:0]               branch_addr_i,
  // Request toward the bus master
  output logic                                trans_valid_o,
  input  logic                                trans_ready_i,
  output pf_pkg::trans_req_t                  trans_o,
  // Response strobe from the bus master
  input  logic                                rsp_valid_i,
  input  logic [`PF_DATA_W-1:0]               rsp_data_i,
  // Queue write side
  output logic                                push_o,
  output pf_pkg::instr_resp_t                 push_data_o,
  output logic                                flush_o,
  input  logic [$clog2(`PF_FIFO_DEPTH+1)-1:0] free_slots_i,
  // Seen by the bound checker
  output pf_pkg::prefetch_state_e             state_o
);

  localparam int unsigned CNT_W = $clog2(`PF_FIFO_DEPTH + 1);
  localparam logic [`PF_ADDR_W-1:0] ADDR_STEP = `PF_ADDR_STEP;

  pf_pkg::prefetch_state_e state_q;
  pf_pkg::prefetch_state_e state_d;
  logic [`PF_ADDR_W-1:0]   fetch_addr_q;
  logic [`PF_ADDR_W-1:0]   cyc_addr_q;
  logic                    started_q;
  logic                    outstanding_q;
  logic                    owed;
  logic                    accept;

  ////////////////////
  // Request side
  ////////////////////

  // Open cycle still owes a word unless it went stale
  assign owed = outstanding_q && (state_q == pf_pkg::IDLE);

  // Branch target goes out in the redirect cycle itself
  assign trans_o.addr = branch_i ? branch_addr_i : fetch_addr_q;

  // Queue is emptied on a branch so the target needs no room check
  // Otherwise keep one slot per word already owed
  assign trans_valid_o = branch_i ||
      (started_q && (state_q == pf_pkg::IDLE) && (free_slots_i > CNT_W'(owed)));

  assign accept = trans_valid_o && trans_ready_i;

  ////////////////////
  // Response side
  ////////////////////

  // Stale data and data racing a branch never reach the queue
  assign push_o           = rsp_valid_i && (state_q == pf_pkg::IDLE) && !branch_i;
  assign push_data_o.addr = cyc_addr_q;
  assign push_data_o.instr = rsp_data_i;
  assign flush_o          = branch_i;

  ////////////////////
  // Discard FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      pf_pkg::IDLE: begin
        // Cycle still open past the branch edge
        if (branch_i && outstanding_q && !rsp_valid_i) begin
          state_d = pf_pkg::BRANCH_WAIT;
        end
      end
      pf_pkg::BRANCH_WAIT: begin
        // Stale ack closes the old cycle
        if (rsp_valid_i) begin
          state_d = pf_pkg::IDLE;
        end
      end
      default: state_d = pf_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= pf_pkg::IDLE;
      started_q     <= 1'b0;
      outstanding_q <= 1'b0;
      fetch_addr_q  <= '0;
    end else begin
      state_q <= state_d;
      // First branch enables fetching
      if (branch_i) begin
        started_q <= 1'b1;
      end
      // Master takes no request while a cycle is open
      if (rsp_valid_i) begin
        outstanding_q <= 1'b0;
      end
      if (accept) begin
        outstanding_q <= 1'b1;
      end
      // Next sequential word or the pending branch target
      if (accept) begin
        fetch_addr_q <= trans_o.addr + ADDR_STEP;
      end else if (branch_i) begin
        fetch_addr_q <= branch_addr_i;
      end
    end
  end

  // Address of the open cycle tagged onto its response
  always_ff @(posedge clk) begin
    if (accept) begin
      cyc_addr_q <= trans_o.addr;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

// ==== design/fetch_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pf_consts.svh"

module fetch_fifo #(
  parameter int unsigned DEPTH = `PF_FIFO_DEPTH
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         flush_i,
  // Write side
  input  logic                         push_i,
  input  pf_pkg::instr_resp_t          push_data_i,
  // Read side with the head shown before pop
  input  logic                         pop_i,
  output logic                         valid_o,
  output pf_pkg::instr_resp_t          data_o,
  output logic [$clog2(DEPTH+1)-1:0]   free_slots_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

  pf_pkg::instr_resp_t mem_q [DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    count_q;
  logic                push_en;
  logic                pop_en;

  // First word falls through
  assign valid_o      = (count_q != '0);
  assign data_o       = mem_q[rd_ptr_q];
  assign free_slots_o = FULL - count_q;

  // Writes beyond the depth are ignored
  assign push_en = push_i && (count_q != FULL);
  assign pop_en  = pop_i && valid_o;

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Flush wins over a push in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_en && !flush_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/wb_fetch_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pf_consts.svh"

module wb_fetch_master (
  input  logic                  clk,
  input  logic                  rst_n,
  // Request from the controller
  input  logic                  trans_valid_i,
  output logic                  trans_ready_o,
  input  pf_pkg::trans_req_t    trans_i,
  // Wishbone classic read port
  output pf_pkg::wb_m2s_t       wb_o,
  input  logic [`PF_DATA_W-1:0] wb_dat_i,
  input  logic                  wb_ack_i,
  // Response strobe back to the controller
  output logic                  rsp_valid_o,
  output logic [`PF_DATA_W-1:0] rsp_data_o
);

  logic                  cyc_q;
  logic [`PF_ADDR_W-1:0] adr_q;
  logic                  start;
  logic                  done;

  ////////////////////
  // Request accept
  ////////////////////

  // Only one cycle open at a time
  assign trans_ready_o = !cyc_q;
  assign start         = trans_valid_i && trans_ready_o;

  // Ack ends the cycle
  assign done = cyc_q && wb_ack_i;

  ////////////////////
  // Bus cycle
  ////////////////////

  // cyc and stb rise and fall together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q <= 1'b0;
    end else if (start) begin
      cyc_q <= 1'b1;
    end else if (done) begin
      cyc_q <= 1'b0;
    end
  end

  // Address held stable for the whole cycle
  always_ff @(posedge clk) begin
    if (start) begin
      adr_q <= trans_i.addr;
    end
  end

  assign wb_o.cyc = cyc_q;
  assign wb_o.stb = cyc_q;
  assign wb_o.adr = adr_q;

  ////////////////////
  // Response
  ////////////////////

  // Read data passes straight through in the ack cycle
  assign rsp_valid_o = done;
  assign rsp_data_o  = wb_dat_i;

endmodule

`default_nettype wire

// ==== design/prefetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pf_consts.svh"

module prefetch_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  // Redirect from the core
  input  logic                  branch_i,
  input  logic [`PF_ADDR_W-1:0] branch_addr_i,
  // Instruction stream to the core
  output logic                  fetch_valid_o,
  input  logic                  fetch_ready_i,
  output pf_pkg::instr_resp_t   fetch_o,
  // Wishbone classic read port
  output pf_pkg::wb_m2s_t       wb_o,
  input  logic [`PF_DATA_W-1:0] wb_dat_i,
  input  logic                  wb_ack_i
);

  localparam int unsigned CNT_W = $clog2(`PF_FIFO_DEPTH + 1);

  // Controller to bus master
  logic                  trans_valid;
  logic                  trans_ready;
  pf_pkg::trans_req_t    trans;
  // Bus master to controller
  logic                  rsp_valid;
  logic [`PF_DATA_W-1:0] rsp_data;
  // Controller to queue
  logic                  push;
  pf_pkg::instr_resp_t   push_data;
  logic                  flush;
  logic [CNT_W-1:0]      free_slots;
  // Core handshake
  logic                  pop;

  assign pop = fetch_valid_o && fetch_ready_i;

  prefetch_ctrl u_prefetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_o       (trans),
    .rsp_valid_i   (rsp_valid),
    .rsp_data_i    (rsp_data),
    .push_o        (push),
    .push_data_o   (push_data),
    .flush_o       (flush),
    .free_slots_i  (free_slots),
    .state_o       ()
  );

  fetch_fifo #(
    .DEPTH (`PF_FIFO_DEPTH)
  ) u_fetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush),
    .push_i       (push),
    .push_data_i  (push_data),
    .pop_i        (pop),
    .valid_o      (fetch_valid_o),
    .data_o       (fetch_o),
    .free_slots_o (free_slots)
  );

  wb_fetch_master u_wb_fetch_master (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_i       (trans),
    .wb_o          (wb_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i),
    .rsp_valid_o   (rsp_valid),
    .rsp_data_o    (rsp_data)
  );

endmodule

`default_nettype wire

// ==== sim/prefetch_unit_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pf_consts.svh"

module prefetch_unit_sva (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    branch_i,
  input logic [`PF_ADDR_W-1:0]   branch_addr_i,
  input logic                    trans_valid_i,
  input logic                    trans_ready_i,
  input pf_pkg::trans_req_t      trans_i,
  input logic                    push_i,
  input pf_pkg::prefetch_state_e state_i
);

  localparam logic [`PF_ADDR_W-1:0] ADDR_STEP = `PF_ADDR_STEP;

  // Count of failed assertions
  int unsigned failures = 0;

  logic                  seen_branch_q;
  logic                  redirect_pending_q;
  logic [`PF_ADDR_W-1:0] last_addr_q;
  logic                  accept;

  assign accept = trans_valid_i && trans_ready_i;

  ////////////////////
  // History of the request stream
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_branch_q      <= 1'b0;
      redirect_pending_q <= 1'b0;
      last_addr_q        <= '0;
    end else begin
      if (branch_i) begin
        seen_branch_q <= 1'b1;
      end
      // Branch target not yet on the bus breaks the sequence
      if (accept) begin
        last_addr_q        <= trans_i.addr;
        redirect_pending_q <= 1'b0;
      end else if (branch_i) begin
        redirect_pending_q <= 1'b1;
      end
    end
  end

  ////////////////////
  // Controller rules
  ////////////////////

  a_branch_addr: assert property (@(posedge clk) disable iff (!rst_n)
      branch_i |-> (trans_i.addr == branch_addr_i))
    else begin
      failures++;
      $error("branch target not presented as the request address");
    end

  a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      trans_valid_i |-> ((trans_i.addr[1:0] == 2'b00) &&
                         (!branch_i || (branch_addr_i[1:0] == 2'b00))))
    else begin
      failures++;
      $error("request or branch address not word aligned");
    end

  a_first_fetch: assert property (@(posedge clk) disable iff (!rst_n)
      (!seen_branch_q && !branch_i) |-> !trans_valid_i)
    else begin
      failures++;
      $error("request made before the first branch");
    end

  a_addr_incr: assert property (@(posedge clk) disable iff (!rst_n)
      ((state_i == pf_pkg::IDLE) && !branch_i && trans_valid_i && !redirect_pending_q)
      |-> (trans_i.addr == last_addr_q + ADDR_STEP))
    else begin
      failures++;
      $error("sequential request address is not the previous one plus the step");
    end

  a_no_push_wait: assert property (@(posedge clk) disable iff (!rst_n)
      (state_i == pf_pkg::BRANCH_WAIT) |-> !push_i)
    else begin
      failures++;
      $error("word pushed while a stale cycle is pending");
    end

endmodule

bind prefetch_ctrl prefetch_unit_sva u_prefetch_unit_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .branch_i      (branch_i),
  .branch_addr_i (branch_addr_i),
  .trans_valid_i (trans_valid_o),
  .trans_ready_i (trans_ready_i),
  .trans_i       (trans_o),
  .push_i        (push_o),
  .state_i       (state_o)
);

`default_nettype wire

// ==== sim/tb_prefetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pf_consts.svh"

module tb_prefetch_unit;

  localparam int unsigned CLK_PERIOD      = 10;
  localparam int unsigned RESET_CYCLES    = 16;
  localparam int unsigned NUM_DELIVERIES  = 2000;
  localparam int unsigned CYCLES_PER_WORD = 20;
  localparam int unsigned WATCHDOG_CYCLES = NUM_DELIVERIES * CYCLES_PER_WORD + RESET_CYCLES;
  localparam int unsigned MIN_STALE       = 20;
  localparam int unsigned STALL_CYCLES    = 30;
  localparam logic [31:0] SEED            = 32'h6e11_4aa7;
  localparam logic [`PF_ADDR_W-1:0] ADDR_STEP = `PF_ADDR_STEP;

  logic                  clk;
  logic                  rst_n;
  logic                  branch;
  logic [`PF_ADDR_W-1:0] branch_addr;
  logic                  fetch_valid;
  logic                  fetch_ready;
  pf_pkg::instr_resp_t   fetch;
  pf_pkg::wb_m2s_t       wb_m2s;
  logic [`PF_DATA_W-1:0] wb_dat;
  logic                  wb_ack;

  // Reference model of the instruction stream
  logic [`PF_ADDR_W-1:0] exp_q[$];
  logic [`PF_ADDR_W-1:0] fetch_exp;
  logic                  stale;
  logic                  started;
  int unsigned           delivered;
  int unsigned           stale_cnt;
  // Memory slave state
  logic                  slave_busy;
  logic [`PF_ADDR_W-1:0] slave_adr;
  int unsigned           slave_wait;
  logic                  ack_seen;
  // Stimulus state
  logic                  first_sent;
  int unsigned           first_delay;
  int unsigned           idle_cnt;
  int unsigned           stall_left;

  prefetch_unit u_prefetch_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .fetch_valid_o (fetch_valid),
    .fetch_ready_i (fetch_ready),
    .fetch_o       (fetch),
    .wb_o          (wb_m2s),
    .wb_dat_i      (wb_dat),
    .wb_ack_i      (wb_ack)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  // Memory content depends on every address bit
  function automatic logic [`PF_DATA_W-1:0] mem_word(input logic [`PF_ADDR_W-1:0] addr);
    logic [31:0] mix;
    mix = addr * 32'h9e37_79b1;
    mix = mix ^ {addr[15:0], addr[31:16]};
    return mix ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [`PF_ADDR_W-1:0] random_target();
    return $urandom() & ~32'h3;
  endfunction

  ////////////////////
  // Core side checks
  ////////////////////

  task automatic check_delivery(input int unsigned occ);
    logic [`PF_ADDR_W-1:0] exp_addr;
    // Queue shows a word exactly when the model holds one
    assert (fetch_valid == (occ != 0)) else
      fail_now($sformatf("MISMATCH at %0t: fetch_valid %0b with %0d words expected",
                         $time, fetch_valid, occ));
    if (fetch_valid && fetch_ready) begin
      exp_addr = exp_q.pop_front();
      assert (fetch.addr == exp_addr) else
        fail_now($sformatf("MISMATCH at %0t: delivered addr %h, expected %h",
                           $time, fetch.addr, exp_addr));
      assert (fetch.instr == mem_word(exp_addr)) else
        fail_now($sformatf("MISMATCH at %0t: instr %h at addr %h, expected %h",
                           $time, fetch.instr, exp_addr, mem_word(exp_addr)));
      delivered++;
    end
  endtask

  ////////////////////
  // Bus slave and fetch model
  ////////////////////

  task automatic serve_bus(input int unsigned occ);
    // Cycle closes on the edge after ack
    if (ack_seen) begin
      assert (!wb_m2s.cyc) else
        fail_now($sformatf("ERROR at %0t: cyc still high after the ack cycle", $time));
    end
    ack_seen = 1'b0;
    assert (!wb_m2s.stb || wb_m2s.cyc) else
      fail_now($sformatf("ERROR at %0t: stb high without cyc", $time));
    if (!started) begin
      assert (!wb_m2s.cyc) else
        fail_now($sformatf("ERROR at %0t: bus cycle opened before the first branch", $time));
    end
    if (wb_ack) begin
      assert (wb_m2s.adr == slave_adr) else
        fail_now($sformatf("MISMATCH at %0t: adr %h changed from %h in ack cycle",
                           $time, wb_m2s.adr, slave_adr));
      wb_ack     <= 1'b0;
      slave_busy = 1'b0;
      ack_seen   = 1'b1;
      if (stale) begin
        // Data of the cycle opened before the branch is dropped
        stale = 1'b0;
      end else if (!branch) begin
        assert (occ < `PF_FIFO_DEPTH) else
          fail_now($sformatf("ERROR at %0t: word acked while the queue was full", $time));
        assert (slave_adr == fetch_exp) else
          fail_now($sformatf("MISMATCH at %0t: fetched addr %h, expected %h",
                             $time, slave_adr, fetch_exp));
        exp_q.push_back(fetch_exp);
        fetch_exp += ADDR_STEP;
      end
    end else if (wb_m2s.cyc) begin
      if (!slave_busy) begin
        // New cycle picks its wait states
        slave_busy = 1'b1;
        slave_adr  = wb_m2s.adr;
        slave_wait = $urandom_range(3, 0);
      end else begin
        assert (wb_m2s.adr == slave_adr) else
          fail_now($sformatf("MISMATCH at %0t: adr %h changed from %h during cycle",
                             $time, wb_m2s.adr, slave_adr));
      end
      if (slave_wait == 0) begin
        wb_ack <= 1'b1;
        wb_dat <= mem_word(slave_adr);
      end else begin
        slave_wait--;
      end
    end
  endtask

  task automatic track_branch();
    if (branch) begin
      // Open cycle without ack goes stale
      if (wb_m2s.cyc && !wb_ack) begin
        stale = 1'b1;
        stale_cnt++;
      end
      exp_q.delete();
      fetch_exp = branch_addr;
      started   = 1'b1;
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_stimulus();
    // One-cycle branch pulses that never come back to back
    if (!first_sent) begin
      if (idle_cnt == first_delay) begin
        branch      <= 1'b1;
        branch_addr <= random_target();
        first_sent  = 1'b1;
      end else begin
        idle_cnt++;
      end
    end else if (!branch && ($urandom_range(99, 0) < 3)) begin
      branch      <= 1'b1;
      branch_addr <= random_target();
    end else begin
      branch <= 1'b0;
    end
    // Random ready with rare long stalls
    if (stall_left != 0) begin
      fetch_ready <= 1'b0;
      stall_left--;
    end else if ($urandom_range(99, 0) == 0) begin
      fetch_ready <= 1'b0;
      stall_left  = STALL_CYCLES - 1;
    end else begin
      fetch_ready <= ($urandom_range(99, 0) < 70);
    end
  endtask

  task automatic run_cycle();
    int unsigned occ;
    occ = exp_q.size();
    check_delivery(occ);
    serve_bus(occ);
    track_branch();
    assert (u_prefetch_unit.u_prefetch_ctrl.u_prefetch_unit_sva.failures == 0) else
      fail_now($sformatf("ERROR at %0t: a bound controller assertion failed", $time));
    drive_stimulus();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(SEED));
    clk         = 1'b0;
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    fetch_ready = 1'b0;
    wb_dat      = '0;
    wb_ack      = 1'b0;
    fetch_exp   = '0;
    stale       = 1'b0;
    started     = 1'b0;
    delivered   = 0;
    stale_cnt   = 0;
    slave_busy  = 1'b0;
    slave_adr   = '0;
    slave_wait  = 0;
    ack_seen    = 1'b0;
    first_sent  = 1'b0;
    idle_cnt    = 0;
    stall_left  = 0;
    first_delay = $urandom_range(8, 1);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    while (delivered < NUM_DELIVERIES) begin
      @(posedge clk);
      run_cycle();
    end
    // Controller rules of the last edge settle by the falling edge
    @(negedge clk);
    if (u_prefetch_unit.u_prefetch_ctrl.u_prefetch_unit_sva.failures != 0) begin
      fail_now($sformatf("ERROR at %0t: a bound controller assertion failed", $time));
    end else if (stale_cnt < MIN_STALE) begin
      fail_now($sformatf("ERROR: only %0d branches hit an open bus cycle, %0d needed",
                         stale_cnt, MIN_STALE));
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

  // Watchdog sized from the delivery budget
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_now($sformatf("ERROR: watchdog expired with %0d of %0d words delivered",
                       delivered, NUM_DELIVERIES));
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/pf_pkg.sv
design/prefetch_ctrl.sv
design/fetch_fifo.sv
design/wb_fetch_master.sv
design/prefetch_unit.sv
sim/prefetch_unit_sva.sv
sim/tb_prefetch_unit.sv
